// ==== hw/tilemap_pkg.sv ====
package tilemap_pkg;

	////////////////////
	// widths
	////////////////////
	// pen is one bit per plane
	localparam int pen_bits   = 3;
	localparam int prio_bits  = 3;
	localparam int color_bits = 8;
	// four pixels per plane in one tile row
	localparam int plane_px   = 4;
	localparam int row_bits   = pen_bits * plane_px;
	localparam int addr_bits  = 3;

	typedef logic [pen_bits-1:0]   pen_t;
	typedef logic [prio_bits-1:0]  prio_t;
	typedef logic [color_bits-1:0] color_t;
	// plane 0 in 3:0, plane 1 in 7:4, plane 2 in 11:8, leftmost px at msb
	typedef logic [row_bits-1:0]   row_t;
	// bit 2 picks the pair, 1:0 the register
	typedef logic [addr_bits-1:0]  cpu_addr_t;

	// all planes set means nothing drawn here
	localparam pen_t pen_transparent = 3'd7;

	////////////////////
	// register map
	////////////////////
	localparam logic [1:0] reg_prio_a = 2'd0;
	localparam logic [1:0] reg_prio_b = 2'd1;
	localparam logic [1:0] reg_ctrl   = 2'd2;

	// cpu data byte, read as priority or as control
	typedef union packed {
		struct packed {
			logic [3:0] rsvd_hi;
			prio_t      prio;     // bits 3:1 like the original chip
			logic       rsvd_lo;
		} prio_view;
		struct packed {
			logic [5:0] rsvd;
			logic       hide_b;
			logic       hide_a;
		} ctrl_view;
	} cpu_word_u;

endpackage

// ==== hw/fetch_timer.sv ====
`timescale 1ns/1ps

module fetch_timer (
	input  logic CLK_6M,
	input  logic rst,
	output logic fetch_a,
	output logic fetch_b
);

	////////////////////
	// tile phase
	////////////////////
	// one tile row of 4 px per phase loop
	logic [1:0] phase;

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			phase <= 2'd0;
		end else begin
			phase <= phase + 2'd1;
		end
	end

	////////////////////
	// load strobes
	////////////////////
	// registered one phase early so each strobe lines up with its phase
	// a on phase 3, b on phase 1, two cycles apart
	// both layers share the row bus on these interleaved slots
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			fetch_a <= 1'b0;
			fetch_b <= 1'b0;
		end else begin
			// next phase is 3
			fetch_a <= (phase == 2'd2);
			// next phase is 1
			fetch_b <= (phase == 2'd0);
		end
	end

endmodule

// ==== hw/tile_shifter.sv ====
`timescale 1ns/1ps

module tile_shifter (
	input  logic                CLK_6M,
	input  logic                rst,
	input  logic                load,
	input  tilemap_pkg::row_t   gdi,
	input  tilemap_pkg::color_t mdi,
	output tilemap_pkg::pen_t   pen,
	output tilemap_pkg::color_t color
);
	import tilemap_pkg::*;

	// one shift register per bit plane
	logic [plane_px-1:0] plane0;
	logic [plane_px-1:0] plane1;
	logic [plane_px-1:0] plane2;

	////////////////////
	// row latch / shift
	////////////////////
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			plane0 <= '0;
			plane1 <= '0;
			plane2 <= '0;
		end else if (load) begin
			// split the row bus into its planes
			plane0 <= gdi[plane_px-1:0];
			plane1 <= gdi[2*plane_px-1:plane_px];
			plane2 <= gdi[3*plane_px-1:2*plane_px];
		end else begin
			// shift left, ones in from the right
			// so an empty row reads as pen 7
			plane0 <= {plane0[plane_px-2:0], 1'b1};
			plane1 <= {plane1[plane_px-2:0], 1'b1};
			plane2 <= {plane2[plane_px-2:0], 1'b1};
		end
	end

	////////////////////
	// attribute latch
	////////////////////
	// holds until the next load of this layer
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			color <= '0;
		end else if (load) begin
			color <= mdi;
		end
	end

	// current pixel is the top bit of each plane
	assign pen = {plane2[plane_px-1], plane1[plane_px-1], plane0[plane_px-1]};

endmodule

// ==== hw/layer_mixer.sv ====
`timescale 1ns/1ps

module layer_mixer (
	input  logic                CLK_6M,
	input  logic                rst,
	// layer a
	input  tilemap_pkg::pen_t   pen_a,
	input  tilemap_pkg::color_t color_a,
	input  tilemap_pkg::prio_t  prio_a,
	input  logic                hide_a,
	// layer b
	input  tilemap_pkg::pen_t   pen_b,
	input  tilemap_pkg::color_t color_b,
	input  tilemap_pkg::prio_t  prio_b,
	input  logic                hide_b,
	// pixel from upstream
	input  tilemap_pkg::prio_t  in_prio,
	input  tilemap_pkg::color_t in_color,
	input  tilemap_pkg::pen_t   in_pen,
	// merged pixel
	output tilemap_pkg::prio_t  out_prio,
	output tilemap_pkg::color_t out_color,
	output tilemap_pkg::pen_t   out_pen
);
	import tilemap_pkg::*;

	logic vis_a;
	logic vis_b;
	logic a_wins;
	logic b_wins;

	////////////////////
	// selection
	////////////////////
	// drawn and not switched off by the cpu
	assign vis_a = (pen_a != pen_transparent) && !hide_a;
	assign vis_b = (pen_b != pen_transparent) && !hide_b;

	// b must beat upstream and, if a shows, beat a too
	assign b_wins = vis_b && (prio_b > in_prio) && (!vis_a || (prio_b > prio_a));
	// a only needs to beat upstream
	assign a_wins = vis_a && (prio_a > in_prio);
	// equal prio keeps upstream, then a over b

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			out_prio  <= '0;
			out_color <= '0;
			out_pen   <= '0;
		end else if (b_wins) begin
			out_prio  <= prio_b;
			out_color <= color_b;
			out_pen   <= pen_b;
		end else if (a_wins) begin
			out_prio  <= prio_a;
			out_color <= color_a;
			out_pen   <= pen_a;
		end else begin
			// pass through
			out_prio  <= in_prio;
			out_color <= in_color;
			out_pen   <= in_pen;
		end
	end

endmodule

// ==== hw/cpu_reg_port.sv ====
`timescale 1ns/1ps

module cpu_reg_port #(
	parameter tilemap_pkg::prio_t reset_prio_0a = 3'd0,
	parameter tilemap_pkg::prio_t reset_prio_0b = 3'd0,
	parameter tilemap_pkg::prio_t reset_prio_1a = 3'd0,
	parameter tilemap_pkg::prio_t reset_prio_1b = 3'd0
) (
	input  logic                   CLK_6M,
	input  logic                   rst,
	input  logic                   cpu_req,
	input  tilemap_pkg::cpu_addr_t cpu_addr,
	input  tilemap_pkg::cpu_word_u cpu_data,
	output logic                   cpu_ack,
	output tilemap_pkg::prio_t     prio_0a,
	output tilemap_pkg::prio_t     prio_0b,
	output tilemap_pkg::prio_t     prio_1a,
	output tilemap_pkg::prio_t     prio_1b,
	output logic                   hide_0a,
	output logic                   hide_0b,
	output logic                   hide_1a,
	output logic                   hide_1b
);
	import tilemap_pkg::*;

	logic       wr_en;
	logic       pair_sel;
	logic [1:0] reg_sel;

	////////////////////
	// handshake
	////////////////////
	// new request: req up while ack still low
	assign wr_en    = cpu_req && !cpu_ack;
	assign pair_sel = cpu_addr[2];
	assign reg_sel  = cpu_addr[1:0];

	// ack rises on the write edge, falls once req is gone
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			cpu_ack <= 1'b0;
		end else if (wr_en) begin
			cpu_ack <= 1'b1;
		end else if (!cpu_req) begin
			cpu_ack <= 1'b0;
		end
	end

	////////////////////
	// registers
	////////////////////
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			prio_0a <= reset_prio_0a;
			prio_0b <= reset_prio_0b;
			prio_1a <= reset_prio_1a;
			prio_1b <= reset_prio_1b;
			hide_0a <= 1'b0;
			hide_0b <= 1'b0;
			hide_1a <= 1'b0;
			hide_1b <= 1'b0;
		end else if (wr_en) begin
			case (reg_sel)
				// priority view, prio in bits 3:1
				reg_prio_a: begin
					if (pair_sel) prio_1a <= cpu_data.prio_view.prio;
					else          prio_0a <= cpu_data.prio_view.prio;
				end
				reg_prio_b: begin
					if (pair_sel) prio_1b <= cpu_data.prio_view.prio;
					else          prio_0b <= cpu_data.prio_view.prio;
				end
				// control view, hide bits at the bottom
				reg_ctrl: begin
					if (pair_sel) begin
						hide_1a <= cpu_data.ctrl_view.hide_a;
						hide_1b <= cpu_data.ctrl_view.hide_b;
					end else begin
						hide_0a <= cpu_data.ctrl_view.hide_a;
						hide_0b <= cpu_data.ctrl_view.hide_b;
					end
				end
				// addr 3 acked, nothing stored
				default: ;
			endcase
		end
	end

endmodule

// ==== hw/tilemap_pair.sv ====
`timescale 1ns/1ps

module tilemap_pair (
	input  logic                CLK_6M,
	input  logic                rst,
	input  logic                load_a,
	input  logic                load_b,
	// shared row and attribute bus
	input  tilemap_pkg::row_t   gdi,
	input  tilemap_pkg::color_t mdi,
	input  tilemap_pkg::prio_t  prio_a,
	input  tilemap_pkg::prio_t  prio_b,
	input  logic                hide_a,
	input  logic                hide_b,
	// upstream pixel
	input  tilemap_pkg::prio_t  in_prio,
	input  tilemap_pkg::color_t in_color,
	input  tilemap_pkg::pen_t   in_pen,
	output tilemap_pkg::prio_t  out_prio,
	output tilemap_pkg::color_t out_color,
	output tilemap_pkg::pen_t   out_pen
);
	import tilemap_pkg::*;

	pen_t   pen_a;
	pen_t   pen_b;
	color_t color_a;
	color_t color_b;

	////////////////////
	// layers
	////////////////////
	// both read the same bus on different slots
	tile_shifter u_shift_a (
		.CLK_6M (CLK_6M),
		.rst    (rst),
		.load   (load_a),
		.gdi    (gdi),
		.mdi    (mdi),
		.pen    (pen_a),
		.color  (color_a)
	);

	tile_shifter u_shift_b (
		.CLK_6M (CLK_6M),
		.rst    (rst),
		.load   (load_b),
		.gdi    (gdi),
		.mdi    (mdi),
		.pen    (pen_b),
		.color  (color_b)
	);

	////////////////////
	// merge over upstream
	////////////////////
	layer_mixer u_mix (
		.CLK_6M    (CLK_6M),
		.rst       (rst),
		.pen_a     (pen_a),
		.color_a   (color_a),
		.prio_a    (prio_a),
		.hide_a    (hide_a),
		.pen_b     (pen_b),
		.color_b   (color_b),
		.prio_b    (prio_b),
		.hide_b    (hide_b),
		.in_prio   (in_prio),
		.in_color  (in_color),
		.in_pen    (in_pen),
		.out_prio  (out_prio),
		.out_color (out_color),
		.out_pen   (out_pen)
	);

endmodule

// ==== hw/tile_layer_chain.sv ====
`timescale 1ns/1ps

module tile_layer_chain #(
	parameter tilemap_pkg::prio_t reset_prio_0a = 3'd1,
	parameter tilemap_pkg::prio_t reset_prio_0b = 3'd2,
	parameter tilemap_pkg::prio_t reset_prio_1a = 3'd3,
	parameter tilemap_pkg::prio_t reset_prio_1b = 3'd4
) (
	input  logic                   CLK_6M,
	input  logic                   rst,
	output logic                   fetch_a,
	output logic                   fetch_b,
	// row feed per pair
	input  tilemap_pkg::row_t      gdi_0,
	input  tilemap_pkg::color_t    mdi_0,
	input  tilemap_pkg::row_t      gdi_1,
	input  tilemap_pkg::color_t    mdi_1,
	// background
	input  tilemap_pkg::prio_t     bg_prio,
	input  tilemap_pkg::color_t    bg_color,
	input  tilemap_pkg::pen_t      bg_pen,
	output tilemap_pkg::prio_t     out_prio,
	output tilemap_pkg::color_t    out_color,
	output tilemap_pkg::pen_t      out_pen,
	// cpu side
	input  logic                   cpu_req,
	input  tilemap_pkg::cpu_addr_t cpu_addr,
	input  tilemap_pkg::cpu_word_u cpu_data,
	output logic                   cpu_ack
);
	import tilemap_pkg::*;

	prio_t  prio_0a, prio_0b, prio_1a, prio_1b;
	logic   hide_0a, hide_0b, hide_1a, hide_1b;
	// pair 0 to pair 1
	prio_t  mid_prio;
	color_t mid_color;
	pen_t   mid_pen;

	////////////////////
	// timing and regs
	////////////////////
	fetch_timer u_timer (
		.CLK_6M  (CLK_6M),
		.rst     (rst),
		.fetch_a (fetch_a),
		.fetch_b (fetch_b)
	);

	cpu_reg_port #(
		.reset_prio_0a (reset_prio_0a),
		.reset_prio_0b (reset_prio_0b),
		.reset_prio_1a (reset_prio_1a),
		.reset_prio_1b (reset_prio_1b)
	) u_regs (
		.CLK_6M (CLK_6M), .rst (rst),
		.cpu_req (cpu_req), .cpu_addr (cpu_addr), .cpu_data (cpu_data), .cpu_ack (cpu_ack),
		.prio_0a (prio_0a), .prio_0b (prio_0b), .prio_1a (prio_1a), .prio_1b (prio_1b),
		.hide_0a (hide_0a), .hide_0b (hide_0b), .hide_1a (hide_1a), .hide_1b (hide_1b)
	);

	////////////////////
	// pixel chain
	////////////////////
	// pair 0 sits on the background
	tilemap_pair u_pair0 (
		.CLK_6M (CLK_6M), .rst (rst), .load_a (fetch_a), .load_b (fetch_b),
		.gdi (gdi_0), .mdi (mdi_0),
		.prio_a (prio_0a), .prio_b (prio_0b), .hide_a (hide_0a), .hide_b (hide_0b),
		.in_prio (bg_prio), .in_color (bg_color), .in_pen (bg_pen),
		.out_prio (mid_prio), .out_color (mid_color), .out_pen (mid_pen)
	);

	// pair 1 on top, drives the outputs
	tilemap_pair u_pair1 (
		.CLK_6M (CLK_6M), .rst (rst), .load_a (fetch_a), .load_b (fetch_b),
		.gdi (gdi_1), .mdi (mdi_1),
		.prio_a (prio_1a), .prio_b (prio_1b), .hide_a (hide_1a), .hide_b (hide_1b),
		.in_prio (mid_prio), .in_color (mid_color), .in_pen (mid_pen),
		.out_prio (out_prio), .out_color (out_color), .out_pen (out_pen)
	);

endmodule

// ==== include/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////
// compare tasks
////////////////////
// the including module declares check_count and error_count (int)
// and CLK_6M, cpu_req, cpu_addr, cpu_data, cpu_ack

task automatic check_pen(input string what, input tilemap_pkg::pen_t got,
		input tilemap_pkg::pen_t exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("error: %s = %h, expected %h at %0t", what, got, exp, $time);
	end
endtask

task automatic check_prio(input string what, input tilemap_pkg::prio_t got,
		input tilemap_pkg::prio_t exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("error: %s = %h, expected %h at %0t", what, got, exp, $time);
	end
endtask

task automatic check_color(input string what, input tilemap_pkg::color_t got,
		input tilemap_pkg::color_t exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("error: %s = %h, expected %h at %0t", what, got, exp, $time);
	end
endtask

////////////////////
// cpu write
////////////////////
// four phase handshake driven on the falling edge
task automatic cpu_write(input tilemap_pkg::cpu_addr_t addr,
		input tilemap_pkg::cpu_word_u data);
	int waited;
	waited = 0;
	@(negedge CLK_6M);
	cpu_addr = addr;
	cpu_data = data;
	cpu_req  = 1'b1;
	// ack due within a few cycles
	while (!cpu_ack && waited < 4) begin
		@(negedge CLK_6M);
		waited++;
	end
	check_count++;
	if (!cpu_ack) begin
		error_count++;
		$display("cpu write to addr %h got no ack within 4 cycles", addr);
	end
	cpu_req = 1'b0;
	// wait out the release phase
	waited = 0;
	while (cpu_ack && waited < 4) begin
		@(negedge CLK_6M);
		waited++;
	end
	check_count++;
	if (cpu_ack) begin
		error_count++;
		$display("cpu ack stayed high after req dropped for addr %h", addr);
	end
endtask

`endif

// ==== test/tb_tile_layer_chain.sv ====
`timescale 1ns/1ps

module tb_tile_layer_chain;
	import tilemap_pkg::*;

	// well above the few hundred cycles the tests take
	localparam int max_cycles = 2000;

	logic      CLK_6M;
	logic      rst;
	logic      fetch_a;
	logic      fetch_b;
	// row bus driven only by the feeder
	row_t      gdi_0 = '0;
	color_t    mdi_0 = '0;
	row_t      gdi_1 = '0;
	color_t    mdi_1 = '0;
	prio_t     bg_prio;
	color_t    bg_color;
	pen_t      bg_pen;
	prio_t     out_prio;
	color_t    out_color;
	pen_t      out_pen;
	logic      cpu_req;
	cpu_addr_t cpu_addr;
	cpu_word_u cpu_data;
	logic      cpu_ack;

	int check_count;
	int error_count;
	int cycle_count;
	int seed;

	// layer order 0a, 0b, 1a, 1b
	pen_t   pen_l[4];
	row_t   row_l[4];
	color_t color_l[4];
	prio_t  prio_l[4];
	logic   hide_l[4];

	`include "tb_checks.svh"

	tile_layer_chain #(
		.reset_prio_0a (3'd1),
		.reset_prio_0b (3'd2),
		.reset_prio_1a (3'd3),
		.reset_prio_1b (3'd4)
	) uut (
		.CLK_6M (CLK_6M), .rst (rst), .fetch_a (fetch_a), .fetch_b (fetch_b),
		.gdi_0 (gdi_0), .mdi_0 (mdi_0), .gdi_1 (gdi_1), .mdi_1 (mdi_1),
		.bg_prio (bg_prio), .bg_color (bg_color), .bg_pen (bg_pen),
		.out_prio (out_prio), .out_color (out_color), .out_pen (out_pen),
		.cpu_req (cpu_req), .cpu_addr (cpu_addr), .cpu_data (cpu_data), .cpu_ack (cpu_ack)
	);

	always #4 CLK_6M = ~CLK_6M;

	////////////////////
	// tile feed
	////////////////////
	// data goes on the bus inside the strobe cycle
	always @(negedge CLK_6M) begin
		if (fetch_a) begin
			gdi_0 = row_l[0];
			mdi_0 = color_l[0];
			gdi_1 = row_l[2];
			mdi_1 = color_l[2];
		end else if (fetch_b) begin
			gdi_0 = row_l[1];
			mdi_0 = color_l[1];
			gdi_1 = row_l[3];
			mdi_1 = color_l[3];
		end
	end

	// run limit
	always @(posedge CLK_6M) begin
		cycle_count++;
		if (cycle_count >= max_cycles) begin
			$display("timeout: run did not finish within %0d cycles", max_cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	////////////////////
	// helpers
	////////////////////
	task automatic check_bit(input string what, input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("error: %s = %h, expected %h", what, got, exp);
		end
	endtask

	// every pixel of the row gets the same pen
	function automatic row_t row_of_pen(input pen_t p);
		return {{4{p[2]}}, {4{p[1]}}, {4{p[0]}}};
	endfunction

	task automatic set_layer_pen(input int layer, input pen_t p);
		pen_l[layer] = p;
		row_l[layer] = row_of_pen(p);
	endtask

	// expected steady output built up from bg through pair 0 and pair 1
	task automatic predict(output prio_t e_prio, output color_t e_color, output pen_t e_pen,
			output int winner);
		int   ia;
		int   ib;
		logic va;
		logic vb;
		e_prio  = bg_prio;
		e_color = bg_color;
		e_pen   = bg_pen;
		winner  = -1;
		for (int pr = 0; pr < 2; pr++) begin
			ia = 2 * pr;
			ib = ia + 1;
			va = (pen_l[ia] != pen_transparent) && !hide_l[ia];
			vb = (pen_l[ib] != pen_transparent) && !hide_l[ib];
			// b needs to beat upstream and a visible a
			// a only needs to beat upstream
			if (vb && prio_l[ib] > e_prio && (!va || prio_l[ib] > prio_l[ia])) begin
				winner = ib;
			end else if (va && prio_l[ia] > e_prio) begin
				winner = ia;
			end
			if (winner == ia || winner == ib) begin
				e_prio  = prio_l[winner];
				e_color = color_l[winner];
				e_pen   = pen_l[winner];
			end
		end
	endtask

	task automatic settle_and_check(input string tag);
		prio_t  e_prio;
		color_t e_color;
		pen_t   e_pen;
		int     w;
		repeat (12) @(negedge CLK_6M);
		predict(e_prio, e_color, e_pen, w);
		check_prio({tag, " out_prio"}, out_prio, e_prio);
		check_color({tag, " out_color"}, out_color, e_color);
		check_pen({tag, " out_pen"}, out_pen, e_pen);
	endtask

	// reserved bits set so only bits 3:1 may count
	task automatic write_prio(input int layer, input prio_t p);
		cpu_addr_t a;
		cpu_word_u d;
		a = {(layer >= 2), ((layer % 2) == 1) ? reg_prio_b : reg_prio_a};
		d = '1;
		d.prio_view.prio = p;
		cpu_write(a, d);
		prio_l[layer] = p;
	endtask

	task automatic write_hide(input int pair);
		cpu_addr_t a;
		cpu_word_u d;
		a = {(pair == 1), reg_ctrl};
		d = '0;
		d.ctrl_view.hide_a = hide_l[2 * pair];
		d.ctrl_view.hide_b = hide_l[2 * pair + 1];
		cpu_write(a, d);
	endtask

	task automatic report_test(input string name, input int checks0, input int errs0);
		$display("%s: %0d checks, %0d errors", name, check_count - checks0,
			error_count - errs0);
	endtask

	////////////////////
	// tests
	////////////////////
	task automatic reset_values();
		int c0;
		int e0;
		c0 = check_count;
		e0 = error_count;
		rst = 1'b1;
		repeat (8) @(negedge CLK_6M);
		// still in reset with all state cleared
		check_prio("out_prio", out_prio, '0);
		check_color("out_color", out_color, '0);
		check_pen("out_pen", out_pen, '0);
		check_bit("fetch_a", fetch_a, 1'b0);
		check_bit("fetch_b", fetch_b, 1'b0);
		check_bit("cpu_ack", cpu_ack, 1'b0);
		rst = 1'b0;
		// phase 0 in this cycle, then b on phase 1 and a on phase 3
		for (int n = 1; n <= 4; n++) begin
			@(negedge CLK_6M);
			check_bit($sformatf("fetch_a phase %0d", n % 4), fetch_a, (n % 4) == 3);
			check_bit($sformatf("fetch_b phase %0d", n % 4), fetch_b, (n % 4) == 1);
		end
		report_test("reset", c0, e0);
	endtask

	task automatic transparent_layers();
		int c0;
		int e0;
		c0 = check_count;
		e0 = error_count;
		for (int i = 0; i < 4; i++) begin
			set_layer_pen(i, pen_transparent);
		end
		settle_and_check("transparent");
		report_test("transparency", c0, e0);
	endtask

	task automatic priority_order();
		int c0;
		int e0;
		c0 = check_count;
		e0 = error_count;
		// distinct opaque pens per layer
		for (int i = 0; i < 4; i++) begin
			set_layer_pen(i, pen_t'(i + 1));
		end
		settle_and_check("reset prio");
		write_prio(3, 3'd1);
		settle_and_check("1b low");
		write_prio(0, 3'd5);
		settle_and_check("0a top");
		// ties with upstream keep upstream
		write_prio(2, 3'd5);
		settle_and_check("1a tie up");
		write_prio(3, 3'd5);
		settle_and_check("1b tie up");
		// ties inside a pair keep a
		write_prio(1, 3'd5);
		settle_and_check("0b tie a");
		write_prio(2, 3'd6);
		write_prio(3, 3'd6);
		settle_and_check("1b tie a");
		report_test("priority", c0, e0);
	endtask

	task automatic hide_layers();
		int     c0;
		int     e0;
		int     w;
		prio_t  e_prio;
		color_t e_color;
		pen_t   e_pen;
		c0 = check_count;
		e0 = error_count;
		for (int n = 0; n < 4; n++) begin
			predict(e_prio, e_color, e_pen, w);
			if (w < 0) begin
				error_count++;
				$display("no visible layer left to hide at step %0d", n);
			end else begin
				hide_l[w] = 1'b1;
				write_hide(w / 2);
				settle_and_check($sformatf("hide %0d", w));
			end
		end
		for (int i = 0; i < 4; i++) begin
			hide_l[i] = 1'b0;
		end
		write_hide(0);
		write_hide(1);
		settle_and_check("unhide");
		// addr 3 acked with no effect while pair 1 shows
		cpu_write(3'b111, 8'hff);
		settle_and_check("addr 3");
		report_test("hide", c0, e0);
	endtask

	task automatic shift_order();
		int   c0;
		int   e0;
		row_t r;
		pen_t px;
		c0 = check_count;
		e0 = error_count;
		write_prio(2, 3'd7);
		set_layer_pen(0, pen_transparent);
		set_layer_pen(1, pen_transparent);
		set_layer_pen(3, pen_transparent);
		repeat (12) @(negedge CLK_6M);
		for (int n = 0; n < 8; n++) begin
			r = row_t'($random(seed));
			row_l[2] = r;
			@(negedge CLK_6M);
			while (!fetch_a) @(negedge CLK_6M);
			// edge E loads r and the pair 1 mixer adds one more edge
			repeat (2) @(posedge CLK_6M);
			for (int k = 0; k < 4; k++) begin
				@(negedge CLK_6M);
				px = {r[11 - k], r[7 - k], r[3 - k]};
				if (px != pen_transparent) begin
					check_pen($sformatf("out_pen px %0d", k), out_pen, px);
					check_prio($sformatf("out_prio px %0d", k), out_prio, 3'd7);
					check_color($sformatf("out_color px %0d", k), out_color, color_l[2]);
				end else begin
					// see-through pixel shows the background
					check_pen($sformatf("out_pen px %0d", k), out_pen, bg_pen);
					check_prio($sformatf("out_prio px %0d", k), out_prio, bg_prio);
					check_color($sformatf("out_color px %0d", k), out_color, bg_color);
				end
			end
		end
		report_test("shift order", c0, e0);
	endtask

	////////////////////
	// main
	////////////////////
	initial begin
		CLK_6M      = 1'b0;
		rst         = 1'b1;
		cpu_req     = 1'b0;
		cpu_addr    = '0;
		cpu_data    = '0;
		bg_prio     = 3'd0;
		bg_color    = 8'h5a;
		bg_pen      = 3'd2;
		check_count = 0;
		error_count = 0;
		cycle_count = 0;
		seed        = 71;
		for (int i = 0; i < 4; i++) begin
			set_layer_pen(i, pen_transparent);
			color_l[i] = color_t'(8'h10 * (i + 1));
			prio_l[i]  = prio_t'(i + 1);
			hide_l[i]  = 1'b0;
		end
		reset_values();
		transparent_layers();
		priority_order();
		hide_layers();
		shift_order();
		$display("total: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+include
hw/tilemap_pkg.sv
hw/fetch_timer.sv
hw/tile_shifter.sv
hw/layer_mixer.sv
hw/cpu_reg_port.sv
hw/tilemap_pair.sv
hw/tile_layer_chain.sv
test/tb_tile_layer_chain.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
	--top-module tb_tile_layer_chain -f files.f -o tb_sim

output="$(./obj_dir/tb_sim)"
echo "$output"

if grep -qx "Testbench passed" <<< "$output"; then
	exit 0
fi
exit 1
